// File: src.f
source/simd_mul_pkg.sv
source/mul_cfg_if.sv
source/mul_cfg_regs.sv
source/lane_twos_comp.sv
source/vedic_mul_unsigned.sv
source/simd_vedic_mul.sv
source/simd_mul_top.sv
dv/simd_mul_checker.sv
dv/simd_mul_tb.sv

// File: Bender.yml
package:
  name: simd_mul

sources:
  - files:
      - source/simd_mul_pkg.sv
      - source/mul_cfg_if.sv
      - source/mul_cfg_regs.sv
      - source/lane_twos_comp.sv
      - source/vedic_mul_unsigned.sv
      - source/simd_vedic_mul.sv
      - source/simd_mul_top.sv
  - target: test
    files:
      - dv/simd_mul_checker.sv
      - dv/simd_mul_tb.sv

// File: dv/simd_mul_tb.sv
/*
  Testbench for simd_mul_top. Programs CTRL over APB, streams a table of
  directed and random operands twice (second pass under random back-pressure)
  and then exercises the APB error responses
*/
`timescale 1ns/1ns
`default_nettype none

module simd_mul_tb import simd_mul_pkg::*; ();

    localparam int clk_period      = 40;
    localparam int num_fixed       = 14;
    localparam int num_rows        = 30;
    localparam int cycles_per_row  = 40;
    localparam int watchdog_cycles = 2*num_rows*cycles_per_row + 400;

    typedef struct packed {
        esize_e      es;
        logic        sgn;
        logic [31:0] a;
        logic [31:0] b;
    } row_t;

    row_t rows [num_rows];

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        in_valid;
    logic        in_ready;
    logic [31:0] a;
    logic [31:0] b;
    logic        out_valid;
    logic        out_ready;
    logic [63:0] z;

    integer      seed;
    esize_e      cfg_esize;
    logic        cfg_signed;
    logic        timing_check;
    logic        bp_phase;
    int          apb_errors;
    int          product_errors;
    int          results;
    int          pending;

    simd_mul_top DUT (
        .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .in_valid(in_valid), .in_ready(in_ready), .a(a), .b(b),
        .out_valid(out_valid), .out_ready(out_ready), .z(z)
    );

    simd_mul_checker u_checker (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_ready(in_ready), .a(a), .b(b),
        .esize(cfg_esize), .is_signed(cfg_signed), .out_valid(out_valid),
        .out_ready(out_ready), .z(z), .timing_check(timing_check),
        .errors(product_errors), .results(results), .pending(pending)
    );

    always #(clk_period/2) clk = ~clk;

    // Random back-pressure phase
    always @(posedge clk) begin
        if (bp_phase) out_ready <= 1'($random(seed));
    end

    task automatic build_table();
        int unsigned pick;
        rows[0]  = '{esize_8,  1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF};
        rows[1]  = '{esize_8,  1'b0, 32'h80FF_0102, 32'h8002_FF7F};
        rows[2]  = '{esize_16, 1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF};
        rows[3]  = '{esize_16, 1'b0, 32'h8000_7FFF, 32'h7FFF_8000};
        rows[4]  = '{esize_32, 1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF};
        rows[5]  = '{esize_32, 1'b0, 32'h8000_0000, 32'h0000_0002};
        rows[6]  = '{esize_8,  1'b1, 32'h8080_8080, 32'h8080_8080};
        rows[7]  = '{esize_8,  1'b1, 32'h80FF_7F01, 32'hFFFF_FF80};
        rows[8]  = '{esize_16, 1'b1, 32'h8000_8000, 32'h8000_8000};
        rows[9]  = '{esize_16, 1'b1, 32'h7FFF_8000, 32'hFFFF_FFFF};
        rows[10] = '{esize_32, 1'b1, 32'h8000_0000, 32'h8000_0000};
        rows[11] = '{esize_32, 1'b1, 32'h8000_0000, 32'hFFFF_FFFF};
        rows[12] = '{esize_32, 1'b1, 32'h7FFF_FFFF, 32'hFFFF_FFFF};
        rows[13] = '{esize_32, 1'b1, 32'h1234_5678, 32'hFEDC_BA98};
        for (int i = num_fixed; i < num_rows; i++) begin
            pick       = $random(seed);
            rows[i].es  = esize_e'(pick % 3);
            rows[i].sgn = 1'($random(seed));
            rows[i].a   = $random(seed);
            rows[i].b   = $random(seed);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            apb_errors++;
            $display("ERR @%0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // Setup and access phase starting just after a rising edge
    task automatic apb_access(input logic write, input logic [3:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rd,
                              output logic slverr);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rd     = prdata;
        slverr = pslverr;
        check_value("pready", 32'(pready), 32'd1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic program_ctrl(input esize_e es, input logic sgn, input logic en);
        logic [31:0] data;
        logic [31:0] rd;
        logic        err;
        data = '0;
        data[ctrl_esize_lsb +: 2] = es;
        data[ctrl_signed_bit]     = sgn;
        data[ctrl_enable_bit]     = en;
        apb_access(1'b1, ctrl_addr, data, rd, err);
        check_value("pslverr on CTRL write", 32'(err), 32'd0);
        apb_access(1'b0, ctrl_addr, '0, rd, err);
        check_value("CTRL readback", rd, data);
        cfg_esize  <= es;
        cfg_signed <= sgn;
    endtask

    // Hold valid until accepted; the next call drives back to back
    task automatic send_operands(input logic [31:0] x, input logic [31:0] y);
        in_valid <= 1'b1;
        a        <= x;
        b        <= y;
        do @(negedge clk); while (!in_ready);
        @(posedge clk);
    endtask

    task automatic run_table();
        for (int i = 0; i < num_rows; i++) begin
            if (i == 0 || rows[i].es != cfg_esize || rows[i].sgn != cfg_signed) begin
                in_valid <= 1'b0;
                program_ctrl(rows[i].es, rows[i].sgn, 1'b1);
            end
            send_operands(rows[i].a, rows[i].b);
        end
        in_valid <= 1'b0;
    endtask

    task automatic drain();
        out_ready <= 1'b1;
        @(negedge clk);
        while (pending != 0) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic check_disabled();
        in_valid <= 1'b1;
        a        <= 32'h0102_0304;
        b        <= 32'h0506_0708;
        repeat (3) begin
            @(negedge clk);
            if (in_ready) begin
                apb_errors++;
                $display("ERR @%0t: in_ready high while enable is clear", $time);
            end
            @(posedge clk);
        end
        in_valid <= 1'b0;
    endtask

    task automatic apb_checks();
        logic [31:0] rd;
        logic        err;
        program_ctrl(esize_16, 1'b1, 1'b1);
        // Reserved element size must leave CTRL alone
        apb_access(1'b1, ctrl_addr, 32'h0000_000B, rd, err);
        check_value("pslverr on reserved esize", 32'(err), 32'd1);
        apb_access(1'b0, ctrl_addr, '0, rd, err);
        check_value("CTRL after reserved write", rd, 32'h0000_000D);
        // Valid CTRL pattern, so an aliased decode would show up in CTRL
        apb_access(1'b1, 4'h8, 32'h0000_0001, rd, err);
        check_value("pslverr on unmapped write", 32'(err), 32'd1);
        apb_access(1'b0, ctrl_addr, '0, rd, err);
        check_value("CTRL after unmapped write", rd, 32'h0000_000D);
        apb_access(1'b0, 4'h8, '0, rd, err);
        check_value("pslverr on unmapped read", 32'(err), 32'd1);
        apb_access(1'b1, count_addr, 32'h0000_1234, rd, err);
        check_value("pslverr on COUNT write", 32'(err), 32'd1);
        apb_access(1'b0, count_addr, '0, rd, err);
        check_value("pslverr on COUNT read", 32'(err), 32'd0);
        check_value("COUNT", rd, 32'(results));
        program_ctrl(esize_8, 1'b0, 1'b0);
        check_disabled();
    endtask

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        $display("Timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        logic [31:0] rd;
        logic        err;
        clk          = 1'b0;
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        in_valid     = 1'b0;
        a            = '0;
        b            = '0;
        out_ready    = 1'b1;
        seed         = 32'h69f1_68f3;
        cfg_esize    = esize_8;
        cfg_signed   = 1'b0;
        timing_check = 1'b1;
        bp_phase     = 1'b0;
        apb_errors   = 0;
        build_table();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        apb_access(1'b0, ctrl_addr, '0, rd, err);
        check_value("CTRL after reset", rd, 32'd0);
        apb_access(1'b0, count_addr, '0, rd, err);
        check_value("COUNT after reset", rd, 32'd0);
        check_disabled();
        run_table();
        drain();
        // Second pass with random out_ready
        timing_check <= 1'b0;
        bp_phase     <= 1'b1;
        run_table();
        bp_phase <= 1'b0;
        @(posedge clk);
        drain();
        timing_check <= 1'b1;
        apb_checks();
        $display("Summary: %0d results, %0d product errors, %0d APB or flow errors",
                 results, product_errors, apb_errors);
        if (product_errors == 0 && apb_errors == 0 && results == 2*num_rows) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule : simd_mul_tb

`default_nettype wire

// File: dv/simd_mul_checker.sv
/*
  Scoreboard for the SIMD multiplier. Queues every accepted operand pair with
  its configuration, predicts the packed product and compares each result
*/
`timescale 1ns/1ns
`default_nettype none

module simd_mul_checker import simd_mul_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  logic                    in_ready,
    input  logic [data_width-1:0]   a,
    input  logic [data_width-1:0]   b,
    input  esize_e                  esize,
    input  logic                    is_signed,
    input  logic                    out_valid,
    input  logic                    out_ready,
    input  logic [result_width-1:0] z,
    input  logic                    timing_check,
    output int                      errors,
    output int                      results,
    output int                      pending
);

    logic [result_width-1:0] expected_q [$];
    longint                  accept_cycle_q [$];
    longint                  cycle;

    // Element i of width w gives a 2w-bit product at bit 2w*i
    function automatic logic [result_width-1:0] expect_product(input logic [31:0] x,
                                                               input logic [31:0] y,
                                                               input esize_e es,
                                                               input logic sgn);
        int          w;
        logic [63:0] mask;
        logic [63:0] pmask;
        logic [63:0] xe;
        logic [63:0] ye;
        logic [63:0] r;
        w = (es == esize_8) ? 8 : (es == esize_16) ? 16 : 32;
        mask  = (64'd1 << w) - 1;
        pmask = (64'd1 << (2*w)) - 1;
        r = '0;
        for (int i = 0; i < 32/w; i++) begin
            xe = (64'(x) >> (i*w)) & mask;
            ye = (64'(y) >> (i*w)) & mask;
            // Sign extension, low 2w bits of the 64-bit product are exact
            if (sgn && xe[w-1]) xe = xe | ~mask;
            if (sgn && ye[w-1]) ye = ye | ~mask;
            r = r | (((xe * ye) & pmask) << (2*i*w));
        end
        return r;
    endfunction

    always @(posedge clk or negedge rst_n) begin : watch
        logic [result_width-1:0] want;
        longint                  started;
        if (!rst_n) begin
            cycle   = 0;
            errors  = 0;
            results = 0;
            pending = 0;
            expected_q.delete();
            accept_cycle_q.delete();
        end else begin
            cycle = cycle + 1;
            if (out_valid && out_ready) begin
                results++;
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("ERR @%0t: result %h with no item in flight", $time, z);
                end else begin
                    want    = expected_q.pop_front();
                    started = accept_cycle_q.pop_front();
                    if (z !== want) begin
                        errors++;
                        $display("ERR @%0t: z %h, expected %h", $time, z, want);
                    end
                    if (timing_check && cycle - started != 2) begin
                        errors++;
                        $display("ERR @%0t: latency %0d cycles, expected 2",
                                 $time, cycle - started);
                    end
                end
            end
            if (in_valid && in_ready) begin
                expected_q.push_back(expect_product(a, b, esize, is_signed));
                accept_cycle_q.push_back(cycle);
            end
            pending = expected_q.size();
        end
    end

endmodule : simd_mul_checker

`default_nettype wire

// File: source/simd_mul_top.sv
/*
  Top level of the SIMD multiplier. Joins the APB register block and the
  pipelined datapath through the configuration interface
*/
`timescale 1ns/1ns
`default_nettype none

module simd_mul_top import simd_mul_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    // APB
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [apb_addr_width-1:0] paddr,
    input  logic [apb_data_width-1:0] pwdata,
    output logic [apb_data_width-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    // Operand and result streams
    input  logic                      in_valid,
    output logic                      in_ready,
    input  logic [data_width-1:0]     a,
    input  logic [data_width-1:0]     b,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic [result_width-1:0]   z
);

    mul_cfg_if cfg_if ();

    mul_cfg_regs u_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .paddr  (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr),
        .cfg    (cfg_if.regs)
    );

    simd_vedic_mul u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .a        (a),
        .b        (b),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .z        (z),
        .cfg      (cfg_if.dp)
    );

endmodule : simd_mul_top

`default_nettype wire

// File: source/simd_vedic_mul.sv
/*
  Two-stage signed/unsigned packed SIMD multiplier on valid/ready streams.
  Stage 1 conditions the sources, stage 2 multiplies and fixes the sign
*/
`timescale 1ns/1ns
`default_nettype none

module simd_vedic_mul import simd_mul_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic [data_width-1:0]   a,
    input  logic [data_width-1:0]   b,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [result_width-1:0] z,
    mul_cfg_if.dp                   cfg
);

    logic advance;
    logic accept;

    logic [num_lanes-1:0]    a_sign;
    logic [num_lanes-1:0]    b_sign;
    logic [num_lanes-1:0]    a_comp;
    logic [num_lanes-1:0]    b_comp;
    logic [result_width-1:0] a_cond;
    logic [result_width-1:0] b_cond;

    logic                    s1_valid;
    logic [data_width-1:0]   s1_a;
    logic [data_width-1:0]   s1_b;
    esize_e                  s1_esize;
    logic [num_lanes-1:0]    s1_res_comp;

    logic [result_width-1:0]                 full_z;
    logic [num_lanes-1:0][2*byte_width-1:0]  diag8;
    logic [num_lanes/2-1:0][data_width-1:0]  diag16;
    logic [result_width-1:0]                 sel_z;
    logic [result_width-1:0]                 fixed_z;

    // Whole pipe stalls on a blocked result
    assign advance  = ~out_valid | out_ready;
    assign in_ready = cfg.enable & advance;
    assign accept   = in_valid & in_ready;
    assign cfg.done = out_valid & out_ready;

    // Sign bit of each element, placed at its lowest lane
    always_comb begin
        a_sign = '0;
        b_sign = '0;
        case (cfg.esize)
            esize_8: begin
                for (int i = 0; i < num_lanes; i++) begin
                    a_sign[i] = a[(i+1)*byte_width-1];
                    b_sign[i] = b[(i+1)*byte_width-1];
                end
            end
            esize_16: begin
                for (int i = 0; i < num_lanes/2; i++) begin
                    a_sign[2*i] = a[(2*i+2)*byte_width-1];
                    b_sign[2*i] = b[(2*i+2)*byte_width-1];
                end
            end
            esize_32: begin
                a_sign[0] = a[data_width-1];
                b_sign[0] = b[data_width-1];
            end
            default: ;
        endcase
    end

    assign a_comp = {num_lanes{cfg.is_signed}} & a_sign;
    assign b_comp = {num_lanes{cfg.is_signed}} & b_sign;

    lane_twos_comp #(.lane_scale(operand_lane_scale)) twos_comp_a (
        .in        ({{(result_width-data_width){1'b0}}, a}),
        .complement(a_comp),
        .esize     (cfg.esize),
        .out       (a_cond)
    );

    lane_twos_comp #(.lane_scale(operand_lane_scale)) twos_comp_b (
        .in        ({{(result_width-data_width){1'b0}}, b}),
        .complement(b_comp),
        .esize     (cfg.esize),
        .out       (b_cond)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s1_valid  <= accept;
            out_valid <= s1_valid;
        end
    end

    // Configuration travels with the item
    always_ff @(posedge clk) begin
        if (accept) begin
            s1_a        <= a_cond[data_width-1:0];
            s1_b        <= b_cond[data_width-1:0];
            s1_esize    <= cfg.esize;
            s1_res_comp <= a_comp ^ b_comp;
        end
    end

    vedic_mul_unsigned u_core (
        .a     (s1_a),
        .b     (s1_b),
        .z     (full_z),
        .diag8 (diag8),
        .diag16(diag16)
    );

    // Lane products come from the diagonals
    always_comb begin
        case (s1_esize)
            esize_8:  sel_z = diag8;
            esize_16: sel_z = diag16;
            default:  sel_z = full_z;
        endcase
    end

    lane_twos_comp #(.lane_scale(result_lane_scale)) twos_comp_z (
        .in        (sel_z),
        .complement(s1_res_comp),
        .esize     (s1_esize),
        .out       (fixed_z)
    );

    always_ff @(posedge clk) begin
        if (advance && s1_valid) begin
            z <= fixed_z;
        end
    end

    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(z));

    // Register block filters the reserved size
    no_reserved_esize: assert property (@(posedge clk) disable iff (!rst_n)
        accept |-> cfg.esize != esize_reserved);

endmodule : simd_vedic_mul

`default_nettype wire

// File: source/vedic_mul_unsigned.sv
/*
  Unsigned 32x32 vedic multiplier. Sixteen 8x8 crosswise blocks combine into
  16x16 products and then the full product; diagonals feed lane selection
*/
`timescale 1ns/1ns
`default_nettype none

module vedic_mul_unsigned import simd_mul_pkg::*; (
    input  logic [data_width-1:0]                   a,
    input  logic [data_width-1:0]                   b,
    output logic [result_width-1:0]                 z,
    output logic [num_lanes-1:0][2*byte_width-1:0]  diag8,
    output logic [num_lanes/2-1:0][data_width-1:0]  diag16
);

    // Byte x byte sub-products, indexed by a byte then b byte
    logic [2*byte_width-1:0] p8  [num_lanes][num_lanes];
    // Halfword x halfword sub-products
    logic [data_width-1:0]   p16 [num_lanes/2][num_lanes/2];

    // Vertically and crosswise, one column sum per output weight
    function automatic logic [2*byte_width-1:0] vedic8(input logic [byte_width-1:0] x,
                                                       input logic [byte_width-1:0] y);
        logic [2*byte_width-1:0] acc;
        logic [3:0]              column;
        acc = '0;
        for (int k = 0; k < 2*byte_width-1; k++) begin
            column = '0;
            for (int i = 0; i < byte_width; i++) begin
                if (k - i >= 0 && k - i < byte_width) begin
                    column = column + (x[i] & y[k-i]);
                end
            end
            acc = acc + ({{(2*byte_width-4){1'b0}}, column} << k);
        end
        return acc;
    endfunction

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            for (int j = 0; j < num_lanes; j++) begin
                p8[i][j] = vedic8(a[i*byte_width +: byte_width], b[j*byte_width +: byte_width]);
            end
        end
    end

    // Low x low, the two cross terms, then high x high
    always_comb begin
        for (int i = 0; i < num_lanes/2; i++) begin
            for (int j = 0; j < num_lanes/2; j++) begin
                p16[i][j] = data_width'(p8[2*i][2*j])
                          + ((data_width'(p8[2*i][2*j+1]) + data_width'(p8[2*i+1][2*j]))
                             << byte_width)
                          + (data_width'(p8[2*i+1][2*j+1]) << (2*byte_width));
            end
        end
    end

    // Same crosswise step one level up
    assign z = result_width'(p16[0][0])
             + ((result_width'(p16[0][1]) + result_width'(p16[1][0])) << (2*byte_width))
             + (result_width'(p16[1][1]) << data_width);

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            diag8[i] = p8[i][i];
        end
        for (int i = 0; i < num_lanes/2; i++) begin
            diag16[i] = p16[i][i];
        end
    end

endmodule : vedic_mul_unsigned

`default_nettype wire

// File: source/lane_twos_comp.sv
/*
  Negates selected elements of a packed word. Element width is the element
  size times the lane scale; operands sit zero-extended in the low half
*/
`timescale 1ns/1ns
`default_nettype none

module lane_twos_comp import simd_mul_pkg::*; #(
    parameter int unsigned lane_scale = operand_lane_scale
) (
    input  logic [result_width-1:0] in,
    input  logic [num_lanes-1:0]    complement,
    input  esize_e                  esize,
    output logic [result_width-1:0] out
);

    // Each element uses the complement bit of its lowest lane
    always_comb begin
        out = in;
        case (esize)
            esize_8: begin
                for (int e = 0; e < num_lanes; e++) begin
                    if (complement[e]) begin
                        out[e*lane_scale*byte_width +: lane_scale*byte_width] =
                            ~in[e*lane_scale*byte_width +: lane_scale*byte_width] + 1'b1;
                    end
                end
            end
            esize_16: begin
                for (int e = 0; e < num_lanes/2; e++) begin
                    if (complement[2*e]) begin
                        out[e*2*lane_scale*byte_width +: 2*lane_scale*byte_width] =
                            ~in[e*2*lane_scale*byte_width +: 2*lane_scale*byte_width] + 1'b1;
                    end
                end
            end
            esize_32: begin
                if (complement[0]) begin
                    out[0 +: num_lanes*lane_scale*byte_width] =
                        ~in[0 +: num_lanes*lane_scale*byte_width] + 1'b1;
                end
            end
            // Reserved size passes through
            default: ;
        endcase
    end

endmodule : lane_twos_comp

`default_nettype wire

// File: source/mul_cfg_regs.sv
/*
  Zero-wait APB slave with the CTRL and COUNT registers. CTRL sets element
  size, signedness and enable of the multiplier; COUNT tallies results
*/
`timescale 1ns/1ns
`default_nettype none

module mul_cfg_regs import simd_mul_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [apb_addr_width-1:0] paddr,
    input  logic [apb_data_width-1:0] pwdata,
    output logic [apb_data_width-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    mul_cfg_if.regs                   cfg
);

    esize_e                    esize_q;
    logic                      signed_q;
    logic                      enable_q;
    logic [apb_data_width-1:0] count_q;

    logic                      access;
    logic                      hit_ctrl;
    logic                      hit_count;
    logic [$bits(esize_e)-1:0] wr_esize;
    logic                      ctrl_we;

    assign access   = psel & penable;
    assign wr_esize = pwdata[ctrl_esize_lsb +: $bits(esize_e)];

    // Address decode
    always_comb begin
        hit_ctrl  = 1'b0;
        hit_count = 1'b0;
        case (paddr)
            ctrl_addr:  hit_ctrl  = 1'b1;
            count_addr: hit_count = 1'b1;
            default: ;
        endcase
    end

    // Unmapped offset, COUNT write or reserved size
    assign pslverr = access & (~(hit_ctrl | hit_count)
                               | (pwrite & hit_count)
                               | (pwrite & hit_ctrl & (wr_esize == esize_reserved)));
    assign pready  = 1'b1;
    assign ctrl_we = access & pwrite & hit_ctrl & ~pslverr;

    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata[ctrl_esize_lsb +: $bits(esize_e)] = esize_q;
            prdata[ctrl_signed_bit]                  = signed_q;
            prdata[ctrl_enable_bit]                  = enable_q;
        end else if (hit_count) begin
            prdata = count_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            esize_q  <= esize_8;
            signed_q <= 1'b0;
            enable_q <= 1'b0;
        end else if (ctrl_we) begin
            esize_q  <= esize_e'(wr_esize);
            signed_q <= pwdata[ctrl_signed_bit];
            enable_q <= pwdata[ctrl_enable_bit];
        end
    end

    // Delivered results, wraps
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (cfg.done) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign cfg.esize     = esize_q;
    assign cfg.is_signed = signed_q;
    assign cfg.enable    = enable_q;

    pslverr_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> psel && penable);

endmodule : mul_cfg_regs

`default_nettype wire

// File: source/mul_cfg_if.sv
/*
  Configuration path from the register block to the multiplier datapath,
  with a done pulse going back for every delivered result
*/
`timescale 1ns/1ns
`default_nettype none

interface mul_cfg_if import simd_mul_pkg::*; ();

    esize_e esize;
    logic   is_signed;
    logic   enable;
    // One pulse per result handshake
    logic   done;

    modport regs (output esize, output is_signed, output enable, input done);

    modport dp (input esize, input is_signed, input enable, output done);

endinterface : mul_cfg_if

`default_nettype wire

// File: source/simd_mul_pkg.sv
/*
  Shared widths, element-size encoding and APB register map for the
  packed SIMD multiplier. Imported by every design block and by the testbench
*/
`default_nettype none

package simd_mul_pkg;

    // Datapath widths
    localparam int data_width   = 32;
    localparam int result_width = 64;
    localparam int byte_width   = 8;
    localparam int num_lanes    = data_width / byte_width;

    // Lane scale of a lane_twos_comp instance, byte lanes or halfword lanes
    localparam int unsigned operand_lane_scale = 1;
    localparam int unsigned result_lane_scale  = 2;

    // Element size of a packed operand, code 3 is reserved
    typedef enum logic [1:0] {
        esize_8  = 2'd0,
        esize_16 = 2'd1,
        esize_32 = 2'd2
    } esize_e;

    localparam logic [1:0] esize_reserved = 2'd3;

    // APB bus
    localparam int apb_addr_width = 4;
    localparam int apb_data_width = 32;

    // Register word offsets
    typedef enum logic [apb_addr_width-1:0] {
        ctrl_addr  = 4'h0,
        count_addr = 4'h4
    } reg_addr_e;

    // CTRL fields
    localparam int ctrl_esize_lsb  = 0;
    localparam int ctrl_signed_bit = 2;
    localparam int ctrl_enable_bit = 3;

endpackage : simd_mul_pkg

`default_nettype wire
